/* verilog/axil_reg_cfg.svh */
// bus widths, timeout and register map for the axi4-lite register slave, included by every rtl file
`ifndef AXIL_REG_CFG_SVH
`define AXIL_REG_CFG_SVH

// axi4-lite bus
`define AXIL_DATA_WIDTH 32
`define AXIL_ADDR_WIDTH 16
`define AXIL_STRB_WIDTH 4        // one bit per byte lane

// cycles a strobe may wait for an ack before the access is forced to complete
`define REG_TIMEOUT 8

// register map, byte addresses of 32-bit words
`define REG_ADDR_ID       16'h0000   // read only
`define REG_ADDR_SCRATCH0 16'h0004
`define REG_ADDR_SCRATCH1 16'h0008
`define REG_ADDR_SCRATCH2 16'h000C
`define REG_ADDR_SCRATCH3 16'h0010
`define REG_ADDR_WR_COUNT 16'h0014   // read only, counts acked writes

`define REG_ID_VALUE 32'h5243_0001

`endif

/* verilog/axil_reg_pkg.sv */
// shared types for the axi4-lite register slave, imported by the front ends, bank and top level
`default_nettype none

`include "axil_reg_cfg.svh"

package axil_reg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register word, seen as one word or as byte lanes
    ////////////////////////////////////////////////////////////////////////////
    typedef union packed {
        logic [`AXIL_DATA_WIDTH-1:0]       word;    // whole word view
        logic [`AXIL_STRB_WIDTH-1:0][7:0] bytes;   // lane view for strobe merge
    } reg_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // axi response codes
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        AXIL_RESP_OKAY   = 2'b00,   // only code this slave returns
        AXIL_RESP_EXOKAY = 2'b01,
        AXIL_RESP_SLVERR = 2'b10,
        AXIL_RESP_DECERR = 2'b11
    } axil_resp_t;

endpackage

`default_nettype wire

/* verilog/axil_reg_rd.sv */
// axi4-lite read channels to a register read strobe with timeout, used as the read side of the top
`timescale 1ns/1ps
`default_nettype none

`include "axil_reg_cfg.svh"

module axil_reg_rd import axil_reg_pkg::*; (
    input  logic                        clk,
    input  logic                        rstn,

    // axi4-lite read slave
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
    input  logic [2:0]                  s_axil_arprot,    // accepted, not checked
    input  logic                        s_axil_arvalid,
    output logic                        s_axil_arready,
    output logic [`AXIL_DATA_WIDTH-1:0] s_axil_rdata,
    output axil_resp_t                  s_axil_rresp,
    output logic                        s_axil_rvalid,
    input  logic                        s_axil_rready,

    // register read port
    output logic [`AXIL_ADDR_WIDTH-1:0] reg_rd_addr,
    output logic                        reg_rd_en,
    input  logic [`AXIL_DATA_WIDTH-1:0] reg_rd_data,
    input  logic                        reg_rd_ack
);

localparam int TIMEOUT_WIDTH = $clog2(`REG_TIMEOUT + 1);
localparam logic [TIMEOUT_WIDTH-1:0] TIMEOUT_LOAD = TIMEOUT_WIDTH'(`REG_TIMEOUT - 1);

logic [TIMEOUT_WIDTH-1:0]    timeout_count_reg, timeout_count_next;
logic [`AXIL_ADDR_WIDTH-1:0] araddr_reg, araddr_next;   // held read address
logic                        arvalid_reg, arvalid_next; // address held
logic [`AXIL_DATA_WIDTH-1:0] rdata_reg, rdata_next;
logic                        rvalid_reg, rvalid_next;
logic                        rd_en_reg, rd_en_next;

assign s_axil_arready = !arvalid_reg;    // free slot takes an address
assign s_axil_rdata   = rdata_reg;
assign s_axil_rresp   = AXIL_RESP_OKAY;
assign s_axil_rvalid  = rvalid_reg;

assign reg_rd_addr = araddr_reg;
assign reg_rd_en   = rd_en_reg;

////////////////////////////////////////////////////////////////////////////
// next state
////////////////////////////////////////////////////////////////////////////
always_comb begin
    timeout_count_next = timeout_count_reg;
    araddr_next        = araddr_reg;
    arvalid_next       = arvalid_reg;
    rdata_next         = rdata_reg;
    rvalid_next        = rvalid_reg && !s_axil_rready;   // drop once taken

    // ack or expired timeout ends the access, register the response
    if (rd_en_reg && (reg_rd_ack || timeout_count_reg == '0)) begin
        arvalid_next = 1'b0;
        rdata_next   = reg_rd_data;   // zero from the bank when unmapped
        rvalid_next  = 1'b1;
    end

    // empty slot, take a new address and rearm the timeout
    if (!arvalid_reg) begin
        araddr_next        = s_axil_araddr;
        arvalid_next       = s_axil_arvalid;
        timeout_count_next = TIMEOUT_LOAD;
    end

    if (rd_en_reg && timeout_count_reg != '0) begin
        timeout_count_next = timeout_count_reg - 1'b1;
    end

    // strobe only while the response slot is free
    rd_en_next = arvalid_next && !rvalid_next;
end

always_ff @(posedge clk) begin
    timeout_count_reg <= timeout_count_next;
    araddr_reg        <= araddr_next;
    arvalid_reg       <= arvalid_next;
    rdata_reg         <= rdata_next;
    rvalid_reg        <= rvalid_next;
    rd_en_reg         <= rd_en_next;

    if (!rstn) begin
        timeout_count_reg <= TIMEOUT_LOAD;
        arvalid_reg       <= 1'b0;
        rvalid_reg        <= 1'b0;
        rd_en_reg         <= 1'b0;
    end
end

endmodule

`default_nettype wire

/* verilog/axil_reg_wr.sv */
// axi4-lite write channels to a register write strobe with timeout, used as the write side of the top
`timescale 1ns/1ps
`default_nettype none

`include "axil_reg_cfg.svh"

module axil_reg_wr import axil_reg_pkg::*; (
    input  logic                        clk,
    input  logic                        rstn,

    // axi4-lite write slave
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
    input  logic [2:0]                  s_axil_awprot,    // accepted, not checked
    input  logic                        s_axil_awvalid,
    output logic                        s_axil_awready,
    input  logic [`AXIL_DATA_WIDTH-1:0] s_axil_wdata,
    input  logic [`AXIL_STRB_WIDTH-1:0] s_axil_wstrb,
    input  logic                        s_axil_wvalid,
    output logic                        s_axil_wready,
    output axil_resp_t                  s_axil_bresp,
    output logic                        s_axil_bvalid,
    input  logic                        s_axil_bready,

    // register write port
    output logic [`AXIL_ADDR_WIDTH-1:0] reg_wr_addr,
    output logic [`AXIL_DATA_WIDTH-1:0] reg_wr_data,
    output logic [`AXIL_STRB_WIDTH-1:0] reg_wr_strb,
    output logic                        reg_wr_en,
    input  logic                        reg_wr_ack
);

localparam int TIMEOUT_WIDTH = $clog2(`REG_TIMEOUT + 1);
localparam logic [TIMEOUT_WIDTH-1:0] TIMEOUT_LOAD = TIMEOUT_WIDTH'(`REG_TIMEOUT - 1);

logic [TIMEOUT_WIDTH-1:0]    timeout_count_reg, timeout_count_next;
logic [`AXIL_ADDR_WIDTH-1:0] awaddr_reg, awaddr_next;
logic                        awvalid_reg, awvalid_next;   // address held
logic [`AXIL_DATA_WIDTH-1:0] wdata_reg, wdata_next;
logic [`AXIL_STRB_WIDTH-1:0] wstrb_reg, wstrb_next;
logic                        wvalid_reg, wvalid_next;     // data held
logic                        bvalid_reg, bvalid_next;
logic                        wr_en_reg, wr_en_next;

assign s_axil_awready = !awvalid_reg;
assign s_axil_wready  = !wvalid_reg;
assign s_axil_bresp   = AXIL_RESP_OKAY;
assign s_axil_bvalid  = bvalid_reg;

assign reg_wr_addr = awaddr_reg;
assign reg_wr_data = wdata_reg;
assign reg_wr_strb = wstrb_reg;
assign reg_wr_en   = wr_en_reg;

////////////////////////////////////////////////////////////////////////////
// next state
////////////////////////////////////////////////////////////////////////////
always_comb begin
    timeout_count_next = timeout_count_reg;
    awaddr_next        = awaddr_reg;
    awvalid_next       = awvalid_reg;
    wdata_next         = wdata_reg;
    wstrb_next         = wstrb_reg;
    wvalid_next        = wvalid_reg;
    bvalid_next        = bvalid_reg && !s_axil_bready;

    // access done, free both slots and post one response
    if (wr_en_reg && (reg_wr_ack || timeout_count_reg == '0)) begin
        awvalid_next = 1'b0;
        wvalid_next  = 1'b0;
        bvalid_next  = 1'b1;
    end

    // aw and w fill independently, in either order
    if (!awvalid_reg) begin
        awaddr_next  = s_axil_awaddr;
        awvalid_next = s_axil_awvalid;
    end
    if (!wvalid_reg) begin
        wdata_next  = s_axil_wdata;
        wstrb_next  = s_axil_wstrb;
        wvalid_next = s_axil_wvalid;
    end

    // rearm until both halves are held
    if (!awvalid_reg || !wvalid_reg) begin
        timeout_count_next = TIMEOUT_LOAD;
    end else if (wr_en_reg && timeout_count_reg != '0) begin
        timeout_count_next = timeout_count_reg - 1'b1;
    end

    wr_en_next = awvalid_next && wvalid_next && !bvalid_next;   // hold off under b stall
end

always_ff @(posedge clk) begin
    timeout_count_reg <= timeout_count_next;
    awaddr_reg        <= awaddr_next;
    awvalid_reg       <= awvalid_next;
    wdata_reg         <= wdata_next;
    wstrb_reg         <= wstrb_next;
    wvalid_reg        <= wvalid_next;
    bvalid_reg        <= bvalid_next;
    wr_en_reg         <= wr_en_next;

    if (!rstn) begin
        timeout_count_reg <= TIMEOUT_LOAD;
        awvalid_reg       <= 1'b0;
        wvalid_reg        <= 1'b0;
        bvalid_reg        <= 1'b0;
        wr_en_reg         <= 1'b0;
    end
end

endmodule

`default_nettype wire

/* verilog/reg_bank.sv */
// register bank behind the axi4-lite front ends: id word, four scratch words and a write counter
`timescale 1ns/1ps
`default_nettype none

`include "axil_reg_cfg.svh"

module reg_bank import axil_reg_pkg::*; (
    input  logic                        clk,
    input  logic                        rstn,

    // read port
    input  logic [`AXIL_ADDR_WIDTH-1:0] reg_rd_addr,
    input  logic                        reg_rd_en,
    output reg_word_t                   reg_rd_data,
    output logic                        reg_rd_ack,

    // write port
    input  logic [`AXIL_ADDR_WIDTH-1:0] reg_wr_addr,
    input  reg_word_t                   reg_wr_data,
    input  logic [`AXIL_STRB_WIDTH-1:0] reg_wr_strb,
    input  logic                        reg_wr_en,
    output logic                        reg_wr_ack
);

reg_word_t                   scratch [4];
logic [`AXIL_DATA_WIDTH-1:0] wr_count;       // acked writes
logic [`AXIL_ADDR_WIDTH-1:0] rd_word_addr;   // byte offset dropped
logic [`AXIL_ADDR_WIDTH-1:0] wr_word_addr;
logic                        rd_hit;
logic                        wr_hit;
logic [3:0]                  wr_scratch_sel; // one hot

assign rd_word_addr = {reg_rd_addr[`AXIL_ADDR_WIDTH-1:2], 2'b00};
assign wr_word_addr = {reg_wr_addr[`AXIL_ADDR_WIDTH-1:2], 2'b00};

////////////////////////////////////////////////////////////////////////////
// read decode, zero and no ack when unmapped
////////////////////////////////////////////////////////////////////////////
always_comb begin
    reg_rd_data = '0;
    rd_hit      = 1'b1;
    case (rd_word_addr)
        `REG_ADDR_ID:       reg_rd_data.word = `REG_ID_VALUE;
        `REG_ADDR_SCRATCH0: reg_rd_data = scratch[0];
        `REG_ADDR_SCRATCH1: reg_rd_data = scratch[1];
        `REG_ADDR_SCRATCH2: reg_rd_data = scratch[2];
        `REG_ADDR_SCRATCH3: reg_rd_data = scratch[3];
        `REG_ADDR_WR_COUNT: reg_rd_data.word = wr_count;
        default:            rd_hit = 1'b0;
    endcase
end

assign reg_rd_ack = reg_rd_en && rd_hit;

////////////////////////////////////////////////////////////////////////////
// write decode, id and count are mapped but read only
////////////////////////////////////////////////////////////////////////////
always_comb begin
    wr_scratch_sel = '0;
    wr_hit         = 1'b1;
    case (wr_word_addr)
        `REG_ADDR_SCRATCH0: wr_scratch_sel[0] = 1'b1;
        `REG_ADDR_SCRATCH1: wr_scratch_sel[1] = 1'b1;
        `REG_ADDR_SCRATCH2: wr_scratch_sel[2] = 1'b1;
        `REG_ADDR_SCRATCH3: wr_scratch_sel[3] = 1'b1;
        `REG_ADDR_ID,
        `REG_ADDR_WR_COUNT: wr_hit = 1'b1;   // acked, nothing stored
        default:            wr_hit = 1'b0;
    endcase
end

assign reg_wr_ack = reg_wr_en && wr_hit;

// commit on the edge closing the ack cycle
always_ff @(posedge clk) begin
    if (!rstn) begin
        for (int i = 0; i < 4; i++) begin
            scratch[i] <= '0;
        end
        wr_count <= '0;
    end else if (reg_wr_ack) begin
        wr_count <= wr_count + 1'b1;   // every acked write counts
        for (int i = 0; i < 4; i++) begin
            for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
                // only strobed lanes of the selected word
                if (wr_scratch_sel[i] && reg_wr_strb[b]) begin
                    scratch[i].bytes[b] <= reg_wr_data.bytes[b];
                end
            end
        end
    end
end

endmodule

`default_nettype wire

/* verilog/axil_reg_top.sv */
// top level of the axi4-lite register slave, joins read and write front ends to the register bank
`timescale 1ns/1ps
`default_nettype none

`include "axil_reg_cfg.svh"

module axil_reg_top import axil_reg_pkg::*; (
    input  logic                        clk,
    input  logic                        rstn,

    // write address, data and response
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
    input  logic [2:0]                  s_axil_awprot,
    input  logic                        s_axil_awvalid,
    output logic                        s_axil_awready,
    input  logic [`AXIL_DATA_WIDTH-1:0] s_axil_wdata,
    input  logic [`AXIL_STRB_WIDTH-1:0] s_axil_wstrb,
    input  logic                        s_axil_wvalid,
    output logic                        s_axil_wready,
    output axil_resp_t                  s_axil_bresp,
    output logic                        s_axil_bvalid,
    input  logic                        s_axil_bready,

    // read address and data
    input  logic [`AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
    input  logic [2:0]                  s_axil_arprot,
    input  logic                        s_axil_arvalid,
    output logic                        s_axil_arready,
    output logic [`AXIL_DATA_WIDTH-1:0] s_axil_rdata,
    output axil_resp_t                  s_axil_rresp,
    output logic                        s_axil_rvalid,
    input  logic                        s_axil_rready
);

// register side read port
logic [`AXIL_ADDR_WIDTH-1:0] reg_rd_addr;
logic                        reg_rd_en;
reg_word_t                   reg_rd_data;
logic                        reg_rd_ack;

// register side write port
logic [`AXIL_ADDR_WIDTH-1:0] reg_wr_addr;
logic [`AXIL_DATA_WIDTH-1:0] reg_wr_data;
logic [`AXIL_STRB_WIDTH-1:0] reg_wr_strb;
logic                        reg_wr_en;
logic                        reg_wr_ack;

axil_reg_rd i_axil_reg_rd (
    .clk            (clk),
    .rstn           (rstn),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arprot  (s_axil_arprot),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .reg_rd_addr    (reg_rd_addr),
    .reg_rd_en      (reg_rd_en),
    .reg_rd_data    (reg_rd_data),   // union passes as its word
    .reg_rd_ack     (reg_rd_ack)
);

axil_reg_wr i_axil_reg_wr (
    .clk            (clk),
    .rstn           (rstn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awprot  (s_axil_awprot),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .reg_wr_addr    (reg_wr_addr),
    .reg_wr_data    (reg_wr_data),
    .reg_wr_strb    (reg_wr_strb),
    .reg_wr_en      (reg_wr_en),
    .reg_wr_ack     (reg_wr_ack)
);

reg_bank i_reg_bank (
    .clk         (clk),
    .rstn        (rstn),
    .reg_rd_addr (reg_rd_addr),
    .reg_rd_en   (reg_rd_en),
    .reg_rd_data (reg_rd_data),
    .reg_rd_ack  (reg_rd_ack),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .reg_wr_strb (reg_wr_strb),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_ack  (reg_wr_ack)
);

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
// clock and reset source for the register slave testbench, 10 ns clock and 3 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
end

// reset low for three rising edges, released just after the third
initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    #1 rstn = 1'b1;
end

endmodule

`default_nettype wire

/* test/tb_axil_reg_top.sv */
// testbench for the axi4-lite register slave that checks random reads and writes against a model
`timescale 1ns/1ps
`default_nettype none

`include "axil_reg_cfg.svh"

module tb_axil_reg_top import axil_reg_pkg::*; ();

localparam int NUM_OPS      = 200;
localparam int NUM_RANDOM   = NUM_OPS - 13;   // 6 reset reads and 7 readbacks
localparam int CYCLE_LIMIT  = NUM_OPS * (`REG_TIMEOUT + 8);
localparam int LAT_MAPPED   = 2;               // handshake cycle to response cycle
localparam int LAT_UNMAPPED = `REG_TIMEOUT + 1;
localparam logic [`AXIL_ADDR_WIDTH-1:0] ADDR_UNMAPPED = 16'h0040;

logic                        clk, rstn;
logic [`AXIL_ADDR_WIDTH-1:0] s_axil_awaddr, s_axil_araddr;
logic [2:0]                  s_axil_awprot, s_axil_arprot;
logic                        s_axil_awvalid, s_axil_awready;
logic [`AXIL_DATA_WIDTH-1:0] s_axil_wdata, s_axil_rdata;
logic [`AXIL_STRB_WIDTH-1:0] s_axil_wstrb;
logic                        s_axil_wvalid, s_axil_wready;
axil_resp_t                  s_axil_bresp, s_axil_rresp;
logic                        s_axil_bvalid, s_axil_bready;
logic                        s_axil_arvalid, s_axil_arready;
logic                        s_axil_rvalid, s_axil_rready;

logic [31:0]                 lfsr;             // random source state
reg_word_t                   model_scratch [4];
logic [`AXIL_DATA_WIDTH-1:0] model_wr_count;
int                          mismatch_count, fail_count, cycle_count;

tb_clk_gen i_clk_gen (.clk(clk), .rstn(rstn));

axil_reg_top i_axil_reg_top (
    .clk(clk), .rstn(rstn),
    .s_axil_awaddr(s_axil_awaddr), .s_axil_awprot(s_axil_awprot),
    .s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
    .s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
    .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
    .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
    .s_axil_bready(s_axil_bready),
    .s_axil_araddr(s_axil_araddr), .s_axil_arprot(s_axil_arprot),
    .s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
    .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
    .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready)
);

////////////////////////////////////////////////////////////////////////////
// random bits and register model
////////////////////////////////////////////////////////////////////////////
// fibonacci lfsr with taps 32 22 2 1 and one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [`AXIL_ADDR_WIDTH-1:0] addr_of(input int idx);
    case (idx)
        0:       return `REG_ADDR_ID;
        1:       return `REG_ADDR_SCRATCH0;
        2:       return `REG_ADDR_SCRATCH1;
        3:       return `REG_ADDR_SCRATCH2;
        4:       return `REG_ADDR_SCRATCH3;
        5:       return `REG_ADDR_WR_COUNT;
        default: return ADDR_UNMAPPED;
    endcase
endfunction

function automatic reg_word_t expected_read(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
    reg_word_t w;
    w.word = '0;                                  // unmapped reads give zero
    case (addr)
        `REG_ADDR_ID:       w.word = `REG_ID_VALUE;
        `REG_ADDR_SCRATCH0: w = model_scratch[0];
        `REG_ADDR_SCRATCH1: w = model_scratch[1];
        `REG_ADDR_SCRATCH2: w = model_scratch[2];
        `REG_ADDR_SCRATCH3: w = model_scratch[3];
        `REG_ADDR_WR_COUNT: w.word = model_wr_count;
        default:            w.word = '0;
    endcase
    return w;
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////
task automatic check_rdata(input string name, input reg_word_t exp, input reg_word_t act);
    if (act.word !== exp.word) begin
        mismatch_count++;
        $display("Mismatch %s: expected %h, actual %h", name, exp.word, act.word);
    end
endtask

task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
        mismatch_count++;
        $display("Mismatch %s resp: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
        mismatch_count++;
        $display("Mismatch %s latency: expected %0d, actual %0d", name, exp, act);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// bus operations entered and left 1 ns after a rising edge
////////////////////////////////////////////////////////////////////////////
task automatic read_op(input string name, input logic [`AXIL_ADDR_WIDTH-1:0] addr);
    reg_word_t act;
    int        lat;
    int        stall;
    s_axil_araddr  = addr;
    s_axil_arprot  = 3'(rand_bits(3));           // ignored by the slave
    s_axil_arvalid = 1'b1;
    @(negedge clk);
    while (!s_axil_arready) @(negedge clk);
    @(posedge clk);                               // ar handshake
    #1 s_axil_arvalid = 1'b0;
    @(negedge clk);
    lat = 1;
    while (!s_axil_rvalid) begin
        @(negedge clk);
        lat++;
    end
    check_latency($sformatf("%s read %h", name, addr),
                  (addr <= `REG_ADDR_WR_COUNT) ? LAT_MAPPED : LAT_UNMAPPED, lat);
    stall = int'(rand_bits(2));                  // 0 to 3 cycles of rready low
    @(posedge clk);
    repeat (stall) @(posedge clk);
    #1 s_axil_rready = 1'b1;
    @(negedge clk);
    if (!s_axil_rvalid) begin
        fail_count++;
        $display("read %h: rvalid dropped before rready was given", addr);
    end
    act.word = s_axil_rdata;
    check_rdata($sformatf("%s read %h", name, addr), expected_read(addr), act);
    check_resp($sformatf("%s read %h", name, addr), AXIL_RESP_OKAY, s_axil_rresp);
    @(posedge clk);
    #1 s_axil_rready = 1'b0;
    @(negedge clk);
    if (s_axil_rvalid) begin
        fail_count++;
        $display("read %h: a second read response followed the first", addr);
    end
    @(posedge clk);
    #1;
endtask

task automatic write_op(input string name, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                        input reg_word_t data, input logic [`AXIL_STRB_WIDTH-1:0] strb);
    logic [1:0] order;
    logic       aw_done, w_done, aw_hs, w_hs;
    int         lat;
    int         stall;
    int         idx;
    order         = 2'(rand_bits(2));             // 0 aw first, 1 w first, else both
    aw_done       = 1'b0;
    w_done        = 1'b0;
    s_axil_awaddr = addr;
    s_axil_awprot = 3'(rand_bits(3));
    s_axil_wdata  = data.word;
    s_axil_wstrb  = strb;
    s_axil_awvalid = (order != 2'd1);
    s_axil_wvalid  = (order != 2'd0);
    while (!(aw_done && w_done)) begin
        @(negedge clk);
        aw_hs = s_axil_awvalid && s_axil_awready;
        w_hs  = s_axil_wvalid && s_axil_wready;
        @(posedge clk);
        #1;
        if (aw_hs) begin
            s_axil_awvalid = 1'b0;
            aw_done        = 1'b1;
        end
        if (w_hs) begin
            s_axil_wvalid = 1'b0;
            w_done        = 1'b1;
        end
        if (aw_done && !w_done) s_axil_wvalid = 1'b1;   // second channel follows
        if (w_done && !aw_done) s_axil_awvalid = 1'b1;
    end
    // latency counted from the later handshake
    @(negedge clk);
    lat = 1;
    while (!s_axil_bvalid) begin
        @(negedge clk);
        lat++;
    end
    check_latency($sformatf("%s write %h", name, addr),
                  (addr <= `REG_ADDR_WR_COUNT) ? LAT_MAPPED : LAT_UNMAPPED, lat);
    stall = int'(rand_bits(2));
    @(posedge clk);
    repeat (stall) @(posedge clk);
    #1 s_axil_bready = 1'b1;
    @(negedge clk);
    if (!s_axil_bvalid) begin
        fail_count++;
        $display("write %h: bvalid dropped before bready was given", addr);
    end
    check_resp($sformatf("%s write %h", name, addr), AXIL_RESP_OKAY, s_axil_bresp);
    @(posedge clk);
    #1 s_axil_bready = 1'b0;
    @(negedge clk);
    if (s_axil_bvalid) begin
        fail_count++;
        $display("write %h: a second write response followed the first", addr);
    end
    // mapped writes count and scratch words take the strobed lanes
    if (addr <= `REG_ADDR_WR_COUNT) model_wr_count++;
    if (addr >= `REG_ADDR_SCRATCH0 && addr <= `REG_ADDR_SCRATCH3) begin
        idx = int'(addr >> 2) - 1;
        for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
            if (strb[b]) model_scratch[idx].bytes[b] = data.bytes[b];
        end
    end
    @(posedge clk);
    #1;
endtask

////////////////////////////////////////////////////////////////////////////
// run
////////////////////////////////////////////////////////////////////////////
initial begin
    reg_word_t data;
    logic      op;
    int        idx;
    lfsr           = 32'h6a63;
    mismatch_count = 0;
    fail_count     = 0;
    model_wr_count = '0;
    for (int i = 0; i < 4; i++) model_scratch[i].word = '0;
    s_axil_awaddr  = '0;
    s_axil_awprot  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arprot  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    @(posedge clk);
    while (!rstn) @(posedge clk);
    #1;
    if (!s_axil_arready || !s_axil_awready || !s_axil_wready
        || s_axil_rvalid || s_axil_bvalid) begin
        fail_count++;
        $display("ready or valid outputs not at their reset values after reset");
    end
    for (int i = 0; i < 6; i++) read_op("reset", addr_of(i));   // ids and zeros
    for (int n = 0; n < NUM_RANDOM; n++) begin
        op        = 1'(rand_bits(1));
        idx       = int'(rand_bits(3) % 7);        // six mapped plus one unmapped
        data.word = rand_bits(32);
        if (op) write_op("random", addr_of(idx), data, 4'(rand_bits(4)));
        else    read_op("random", addr_of(idx));
    end
    for (int i = 0; i < 7; i++) read_op("readback", addr_of(i));
    $display("%0d mismatches, %0d other errors", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

// watchdog
initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
        @(posedge clk);
        cycle_count++;
    end
    fail_count++;
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("%0d mismatches, %0d other errors", mismatch_count, fail_count);
    $display("tests failed");
    $finish;
end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/axil_reg_pkg.sv
verilog/axil_reg_rd.sv
verilog/axil_reg_wr.sv
verilog/reg_bank.sv
verilog/axil_reg_top.sv
test/tb_clk_gen.sv
test/tb_axil_reg_top.sv
